//--- all.f
sched_pkg.sv
rr_arbiter.sv
slot_fifo.sv
max_count_finder.sv
sched_ctrl.sv
pkt_scheduler.sv
tb_pkt_scheduler.sv

//--- tb_pkt_scheduler.sv
`timescale 1ns/1ps

module tb_pkt_scheduler;

  typedef struct packed {
    logic [2:0]  n_desc;
    logic [7:0]  cores;       // Core of descriptor i at bits 2i+1:2i
    logic [11:0] slots;       // Slot of descriptor i at bits 3i+2:3i
    logic        port;
    logic [3:0]  len;
    logic [7:0]  ready_mask;  // data_m_tready pattern that repeats every 8 cycles
  } step_t;

  logic clk;
  logic rst;
  logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] rx_tdata, data_m_tdata;
  logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] data_s_tdata, tx_tdata;
  logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] rx_tkeep, data_m_tkeep;
  logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] data_s_tkeep, tx_tkeep;
  logic [sched_pkg::PORT_COUNT-1:0] rx_tvalid, rx_tready, rx_tlast;
  logic [sched_pkg::PORT_COUNT-1:0] data_m_tvalid, data_m_tready, data_m_tlast;
  logic [sched_pkg::PORT_COUNT-1:0] data_s_tvalid, data_s_tready, data_s_tlast;
  logic [sched_pkg::PORT_COUNT-1:0] tx_tvalid, tx_tready, tx_tlast;
  logic [sched_pkg::PORT_COUNT*sched_pkg::TAG_WIDTH-1:0] data_m_tdest;
  logic [sched_pkg::DATA_WIDTH-1:0] desc_data;
  sched_pkg::core_id_t desc_core, cmd_dest;
  logic desc_valid, desc_ready, cmd_valid, cmd_ready;

  // Reference model state
  logic [sched_pkg::PORT_COUNT-1:0] m_dv;
  sched_pkg::tag_t m_tag [sched_pkg::PORT_COUNT];
  sched_pkg::slot_t q_mem [sched_pkg::CORE_COUNT][sched_pkg::SLOT_COUNT];
  int q_rd [sched_pkg::CORE_COUNT];
  int q_n [sched_pkg::CORE_COUNT];
  int m_ptr, m_cmd;
  logic [sched_pkg::PORT_COUNT-1:0] acc_rx;
  logic acc_desc;
  int test_err, total_err, tests_ok, tests_bad;
  int unsigned seed_value;
  step_t steps [6];

  pkt_scheduler u_pkt_scheduler (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    test_err++;
  endtask

  task automatic finish_test(input string name);
    if (test_err == 0) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", name, test_err);
      tests_bad++;
    end
    total_err += test_err;
    test_err = 0;
  endtask

  // Checks the current cycle and then steps the model across the clock edge
  task automatic run_cycle();
    logic [sched_pkg::PORT_COUNT-1:0] last, req, dv_next;
    logic avail, push_ok;
    int g, best, idx;
    #1;
    for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
      if (data_m_tvalid[p] !== (rx_tvalid[p] & m_dv[p]))
        report_mismatch("data_m_tvalid", data_m_tvalid[p], rx_tvalid[p] & m_dv[p]);
      if (rx_tready[p] !== (data_m_tready[p] & m_dv[p]))
        report_mismatch("rx_tready", rx_tready[p], data_m_tready[p] & m_dv[p]);
      if (rx_tvalid[p] && rx_tready[p]) begin
        if (data_m_tdest[p*sched_pkg::TAG_WIDTH +: sched_pkg::TAG_WIDTH] !== m_tag[p])
          report_mismatch("data_m_tdest",
                          data_m_tdest[p*sched_pkg::TAG_WIDTH +: sched_pkg::TAG_WIDTH], m_tag[p]);
        if (data_m_tdata[p*32 +: 32] !== rx_tdata[p*32 +: 32])
          report_mismatch("data_m_tdata", data_m_tdata[p*32 +: 32], rx_tdata[p*32 +: 32]);
        if (data_m_tkeep[p*4 +: 4] !== rx_tkeep[p*4 +: 4])
          report_mismatch("data_m_tkeep", data_m_tkeep[p*4 +: 4], rx_tkeep[p*4 +: 4]);
        if (data_m_tlast[p] !== rx_tlast[p])
          report_mismatch("data_m_tlast", data_m_tlast[p], rx_tlast[p]);
      end
    end
    if (tx_tdata !== data_s_tdata)
      report_mismatch("tx_tdata", tx_tdata, data_s_tdata);
    if ({tx_tkeep, tx_tvalid, tx_tlast} !== {data_s_tkeep, data_s_tvalid, data_s_tlast})
      report_mismatch("tx_tkeep/tvalid/tlast", {tx_tkeep, tx_tvalid, tx_tlast},
                      {data_s_tkeep, data_s_tvalid, data_s_tlast});
    if (data_s_tready !== tx_tready)
      report_mismatch("data_s_tready", data_s_tready, tx_tready);
    if (desc_ready !== (q_n[desc_core] < sched_pkg::SLOT_COUNT))
      report_mismatch("desc_ready", desc_ready, q_n[desc_core] < sched_pkg::SLOT_COUNT);
    if (cmd_valid !== (m_cmd < sched_pkg::CORE_COUNT))
      report_mismatch("cmd_valid", cmd_valid, m_cmd < sched_pkg::CORE_COUNT);
    if (cmd_valid && cmd_dest !== sched_pkg::core_id_t'(m_cmd))
      report_mismatch("cmd_dest", cmd_dest, m_cmd);
    acc_rx   = rx_tvalid & rx_tready;
    acc_desc = desc_valid & desc_ready;

    last = rx_tvalid & data_m_tready & m_dv & rx_tlast;
    req  = ~m_dv | last;
    g    = -1;
    for (int i = 0; i < sched_pkg::PORT_COUNT; i++) begin
      idx = (m_ptr + i) % sched_pkg::PORT_COUNT;
      if (g < 0 && req[idx]) g = idx;
    end
    avail = 1'b0;
    best  = 0;
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      if (q_n[c] > 0) avail = 1'b1;
      if (q_n[c] > q_n[best]) best = c;
    end
    push_ok = desc_valid && (q_n[desc_core] < sched_pkg::SLOT_COUNT);
    dv_next = m_dv & ~last;
    if (g >= 0) begin
      dv_next[g] = avail;
      m_ptr = (g + 1) % sched_pkg::PORT_COUNT;
      if (avail) begin
        m_tag[g] = {sched_pkg::core_id_t'(best), q_mem[best][q_rd[best]]};
        q_rd[best] = (q_rd[best] + 1) % sched_pkg::SLOT_COUNT;
        q_n[best]--;
      end
    end
    if (push_ok) begin
      idx = (q_rd[desc_core] + q_n[desc_core]) % sched_pkg::SLOT_COUNT;
      q_mem[desc_core][idx] = desc_data[sched_pkg::LEN_WIDTH +: sched_pkg::SLOT_WIDTH];
      q_n[desc_core]++;
    end
    m_dv = dv_next;
    if (m_cmd < sched_pkg::CORE_COUNT && cmd_ready) m_cmd++;

    @(posedge clk);
    #5;
    data_s_tdata  = {$urandom, $urandom};
    data_s_tkeep  = $urandom;
    data_s_tvalid = $urandom;
    data_s_tlast  = $urandom;
    tx_tready     = $urandom;
  endtask

  task automatic load_desc(input int core, input int slot);
    int guard;
    desc_core  = sched_pkg::core_id_t'(core);
    desc_data  = $urandom;
    desc_data[sched_pkg::LEN_WIDTH +: sched_pkg::SLOT_WIDTH] = sched_pkg::slot_t'(slot);
    desc_valid = 1'b1;
    acc_desc   = 1'b0;
    guard      = 0;
    while (!acc_desc && guard < 50) begin
      run_cycle();
      guard++;
    end
    desc_valid = 1'b0;
    if (!acc_desc) begin
      $display("descriptor for core %0d was never accepted", core);
      test_err++;
    end
    run_cycle();
  endtask

  task automatic send_frame(input int p, input int len, input logic [7:0] mask);
    int beat, guard;
    beat = 0;
    guard = 0;
    rx_tvalid[p] = 1'b1;
    rx_tdata[p*32 +: 32] = $urandom;
    rx_tkeep[p*4 +: 4] = $urandom;
    rx_tlast[p] = (len == 1);
    while (beat < len && guard < 200) begin
      data_m_tready[p] = mask[guard % 8];
      run_cycle();
      if (acc_rx[p]) begin
        beat++;
        rx_tdata[p*32 +: 32] = $urandom;
        rx_tkeep[p*4 +: 4] = $urandom;
        rx_tlast[p] = (beat == len - 1);
      end
      guard++;
    end
    rx_tvalid[p] = 1'b0;
    rx_tlast[p] = 1'b0;
    data_m_tready[p] = 1'b0;
    if (beat < len) begin
      $display("frame on port %0d stopped after %0d of %0d beats", p, beat, len);
      test_err++;
    end
  endtask

  initial begin
    int guard;
    seed_value = 32'h8828_bf41;
    seed_value = $urandom(seed_value);
    rst = 1'b1;
    {rx_tdata, rx_tkeep, rx_tvalid, rx_tlast, data_m_tready} = '0;
    {data_s_tdata, data_s_tkeep, data_s_tvalid, data_s_tlast, tx_tready} = '0;
    {desc_data, desc_core, desc_valid, cmd_ready} = '0;
    m_dv = '0;
    m_ptr = 0;
    m_cmd = 0;
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      q_rd[c] = 0;
      q_n[c] = 0;
    end
    {test_err, total_err, tests_ok, tests_bad} = '0;
    steps[0] = {3'd2, 8'h09, 12'o0065, 1'b0, 4'd3, 8'hff};
    steps[1] = {3'd3, 8'h30, 12'o0421, 1'b1, 4'd4, 8'hb6};
    steps[2] = {3'd3, 8'h3a, 12'o0307, 1'b0, 4'd2, 8'h5a};
    steps[3] = {3'd0, 8'h00, 12'o0000, 1'b1, 4'd5, 8'hcc};
    steps[4] = {3'd0, 8'h00, 12'o0000, 1'b0, 4'd1, 8'h0f};
    steps[5] = {3'd1, 8'h01, 12'o0001, 1'b1, 4'd2, 8'hff};
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;

    guard = 0;
    while (m_cmd < sched_pkg::CORE_COUNT && guard < 100) begin
      cmd_ready = $urandom;
      run_cycle();
      guard++;
    end
    if (m_cmd < sched_pkg::CORE_COUNT) begin
      $display("reset commands stopped after %0d of 4", m_cmd);
      test_err++;
    end
    repeat (20) begin
      cmd_ready = $urandom;
      run_cycle();
    end
    finish_test("reset commands");

    rx_tvalid = '1;
    data_m_tready = '1;
    repeat (10) run_cycle();
    rx_tvalid = '0;
    data_m_tready = '0;
    finish_test("no destination");

    for (int s = 0; s < 6; s++) begin
      for (int i = 0; i < steps[s].n_desc; i++)
        load_desc(steps[s].cores[2*i +: 2], steps[s].slots[3*i +: 3]);
      send_frame(steps[s].port, steps[s].len, steps[s].ready_mask);
      finish_test($sformatf("frame step %0d", s));
    end

    repeat (20) run_cycle();
    finish_test("tx pass-through");

    // Core 3 fills up because both ports hold a tag here
    guard = 0;
    while (q_n[3] < sched_pkg::SLOT_COUNT && guard < 8) begin
      load_desc(3, guard);
      guard++;
    end
    desc_core = 2'd3;
    #1;
    if (desc_ready !== 1'b0) report_mismatch("desc_ready core 3", desc_ready, 1'b0);
    run_cycle();
    desc_core = 2'd0;
    #1;
    if (desc_ready !== 1'b1) report_mismatch("desc_ready core 0", desc_ready, 1'b1);
    run_cycle();
    finish_test("full fifo");

    $display("%0d tests ok, %0d tests with errors, %0d errors total",
             tests_ok, tests_bad, total_err);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- pkt_scheduler.sv
`timescale 1ns/1ps

module pkt_scheduler (
  input  logic                                                   clk,
  input  logic                                                   rst,

  // Ethernet receive lanes
  input  logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] rx_tdata,
  input  logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] rx_tkeep,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       rx_tvalid,
  output logic [sched_pkg::PORT_COUNT-1:0]                       rx_tready,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       rx_tlast,

  // Frames toward the cores
  output logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] data_m_tdata,
  output logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] data_m_tkeep,
  output logic [sched_pkg::PORT_COUNT-1:0]                       data_m_tvalid,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       data_m_tready,
  output logic [sched_pkg::PORT_COUNT-1:0]                       data_m_tlast,
  output logic [sched_pkg::PORT_COUNT*sched_pkg::TAG_WIDTH-1:0]  data_m_tdest,

  // Frames from the cores
  input  logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] data_s_tdata,
  input  logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] data_s_tkeep,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       data_s_tvalid,
  output logic [sched_pkg::PORT_COUNT-1:0]                       data_s_tready,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       data_s_tlast,

  // Ethernet transmit lanes
  output logic [sched_pkg::PORT_COUNT*sched_pkg::DATA_WIDTH-1:0] tx_tdata,
  output logic [sched_pkg::PORT_COUNT*sched_pkg::KEEP_WIDTH-1:0] tx_tkeep,
  output logic [sched_pkg::PORT_COUNT-1:0]                       tx_tvalid,
  input  logic [sched_pkg::PORT_COUNT-1:0]                       tx_tready,
  output logic [sched_pkg::PORT_COUNT-1:0]                       tx_tlast,

  // Free slot descriptors
  input  logic [sched_pkg::DATA_WIDTH-1:0]                       desc_data,
  input  sched_pkg::core_id_t                                    desc_core,
  input  logic                                                   desc_valid,
  output logic                                                   desc_ready,

  // Core reset commands
  output sched_pkg::core_id_t                                    cmd_dest,
  output logic                                                   cmd_valid,
  input  logic                                                   cmd_ready
);

  logic [sched_pkg::CORE_COUNT-1:0]    slot_push;
  sched_pkg::slot_t                    pushed_slot;
  logic [sched_pkg::CORE_COUNT-1:0]    slot_ready;
  logic [sched_pkg::CORE_COUNT-1:0]    slot_valid;
  sched_pkg::slot_t                    slot_head [sched_pkg::CORE_COUNT];
  sched_pkg::count_t                   slot_count [sched_pkg::CORE_COUNT];
  logic [sched_pkg::CORE_COUNT-1:0]    slot_pop;
  sched_pkg::core_id_t                 best_core;
  logic [sched_pkg::PORT_COUNT-1:0]    req;
  logic                                grant_valid;
  logic [sched_pkg::PORT_ID_WIDTH-1:0] grant_index;

  sched_ctrl u_sched_ctrl (
    .clk           (clk),
    .rst           (rst),
    .desc_data     (desc_data),
    .desc_core     (desc_core),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .slot_push     (slot_push),
    .pushed_slot   (pushed_slot),
    .slot_ready    (slot_ready),
    .slot_valid    (slot_valid),
    .slot_head     (slot_head),
    .slot_pop      (slot_pop),
    .best_core     (best_core),
    .req           (req),
    .grant_valid   (grant_valid),
    .grant_index   (grant_index),
    .rx_tvalid     (rx_tvalid),
    .rx_tlast      (rx_tlast),
    .rx_tready     (rx_tready),
    .data_m_tready (data_m_tready),
    .data_m_tvalid (data_m_tvalid),
    .data_m_tdest  (data_m_tdest),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_dest      (cmd_dest)
  );

  rr_arbiter u_rr_arbiter (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .grant       (),
    .grant_valid (grant_valid),
    .grant_index (grant_index)
  );

  for (genvar c = 0; c < sched_pkg::CORE_COUNT; c++) begin : g_core
    slot_fifo u_slot_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (slot_push[c]),
      .push_slot (pushed_slot),
      .ready     (slot_ready[c]),
      .pop       (slot_pop[c]),
      .valid     (slot_valid[c]),
      .head      (slot_head[c]),
      .count     (slot_count[c])
    );
  end

  max_count_finder u_max_count_finder (
    .counts    (slot_count),
    .best_core (best_core)
  );

  // Payload lanes are plain wires
  assign data_m_tdata  = rx_tdata;
  assign data_m_tkeep  = rx_tkeep;
  assign data_m_tlast  = rx_tlast;

  assign tx_tdata      = data_s_tdata;
  assign tx_tkeep      = data_s_tkeep;
  assign tx_tvalid     = data_s_tvalid;
  assign tx_tlast      = data_s_tlast;
  assign data_s_tready = tx_tready;

endmodule

//--- sched_ctrl.sv
`timescale 1ns/1ps

module sched_ctrl (
  input  logic                                         clk,
  input  logic                                         rst,

  input  logic [sched_pkg::DATA_WIDTH-1:0]             desc_data,
  input  sched_pkg::core_id_t                          desc_core,
  input  logic                                         desc_valid,
  output logic                                         desc_ready,

  output logic [sched_pkg::CORE_COUNT-1:0]             slot_push,
  output sched_pkg::slot_t                             pushed_slot,
  input  logic [sched_pkg::CORE_COUNT-1:0]             slot_ready,
  input  logic [sched_pkg::CORE_COUNT-1:0]             slot_valid,
  input  sched_pkg::slot_t                             slot_head [sched_pkg::CORE_COUNT],
  output logic [sched_pkg::CORE_COUNT-1:0]             slot_pop,
  input  sched_pkg::core_id_t                          best_core,

  output logic [sched_pkg::PORT_COUNT-1:0]             req,
  input  logic                                         grant_valid,
  input  logic [sched_pkg::PORT_ID_WIDTH-1:0]          grant_index,

  input  logic [sched_pkg::PORT_COUNT-1:0]             rx_tvalid,
  input  logic [sched_pkg::PORT_COUNT-1:0]             rx_tlast,
  output logic [sched_pkg::PORT_COUNT-1:0]             rx_tready,
  input  logic [sched_pkg::PORT_COUNT-1:0]             data_m_tready,
  output logic [sched_pkg::PORT_COUNT-1:0]             data_m_tvalid,
  output logic [sched_pkg::PORT_COUNT*sched_pkg::TAG_WIDTH-1:0] data_m_tdest,

  output logic                                         cmd_valid,
  input  logic                                         cmd_ready,
  output sched_pkg::core_id_t                          cmd_dest
);

  logic [sched_pkg::PORT_COUNT-1:0] dest_valid;
  sched_pkg::tag_t                  dest_tag [sched_pkg::PORT_COUNT];
  logic [sched_pkg::PORT_COUNT-1:0] last_beat;
  logic                             slot_available;
  logic                             assign_dest;
  logic [sched_pkg::CORE_ID_WIDTH:0] cmd_count;

  // Descriptor decode
  assign desc_ready  = slot_ready[desc_core];
  assign pushed_slot = desc_data[sched_pkg::LEN_WIDTH +: sched_pkg::SLOT_WIDTH];

  always_comb begin
    for (int i = 0; i < sched_pkg::CORE_COUNT; i++) begin
      slot_push[i] = desc_valid && desc_ready && (desc_core == i);
      slot_pop[i]  = assign_dest && (best_core == i);
    end
  end

  // A grant with every FIFO empty is simply lost
  assign slot_available = |slot_valid;
  assign assign_dest    = grant_valid && slot_available;

  assign last_beat = rx_tvalid & rx_tready & rx_tlast;
  assign req       = ~dest_valid | last_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_valid <= '0;
    end else begin
      dest_valid <= dest_valid & ~last_beat;
      if (grant_valid) begin
        dest_valid[grant_index] <= slot_available;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (assign_dest) begin
      dest_tag[grant_index] <= {best_core, slot_head[best_core]};
    end
  end

  // Frames pass only while the port holds a tag
  assign data_m_tvalid = rx_tvalid & dest_valid;
  assign rx_tready     = data_m_tready & dest_valid;

  for (genvar p = 0; p < sched_pkg::PORT_COUNT; p++) begin : g_tdest
    assign data_m_tdest[p*sched_pkg::TAG_WIDTH +: sched_pkg::TAG_WIDTH] = dest_tag[p];
  end

  // One reset command per core after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_count <= '0;
    end else if (cmd_valid && cmd_ready) begin
      cmd_count <= cmd_count + 1'b1;
    end
  end

  assign cmd_valid = (cmd_count < sched_pkg::CORE_COUNT);
  assign cmd_dest  = cmd_count[sched_pkg::CORE_ID_WIDTH-1:0];

  a_pop_not_empty: assert property (
    @(posedge clk) disable iff (rst) (slot_pop & ~slot_valid) == '0
  ) else $error("sched_ctrl pops an empty slot FIFO");

endmodule

//--- max_count_finder.sv
`timescale 1ns/1ps

module max_count_finder (
  input  sched_pkg::count_t   counts [sched_pkg::CORE_COUNT],
  output sched_pkg::core_id_t best_core
);

  // Heap layout, node k has children 2k+1 and 2k+2, leaves at the end
  sched_pkg::count_t   node_val [2*sched_pkg::CORE_COUNT-1];
  sched_pkg::core_id_t node_idx [2*sched_pkg::CORE_COUNT-1];

  always_comb begin
    for (int i = 0; i < sched_pkg::CORE_COUNT; i++) begin
      node_val[sched_pkg::CORE_COUNT-1+i] = counts[i];
      node_idx[sched_pkg::CORE_COUNT-1+i] = sched_pkg::core_id_t'(i);
    end

    // Left child always covers the lower indices
    for (int k = sched_pkg::CORE_COUNT-2; k >= 0; k--) begin
      if (node_val[2*k+2] > node_val[2*k+1]) begin
        node_val[k] = node_val[2*k+2];
        node_idx[k] = node_idx[2*k+2];
      end else begin
        // Tie keeps the lower index
        node_val[k] = node_val[2*k+1];
        node_idx[k] = node_idx[2*k+1];
      end
    end

    best_core = node_idx[0];
  end

endmodule

//--- slot_fifo.sv
`timescale 1ns/1ps

module slot_fifo (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  sched_pkg::slot_t  push_slot,
  output logic              ready,
  input  logic              pop,
  output logic              valid,
  output sched_pkg::slot_t  head,
  output sched_pkg::count_t count
);

  // Depth is a power of two, so the pointers wrap by themselves
  logic [sched_pkg::SLOT_WIDTH-2:0] wr_ptr;
  logic [sched_pkg::SLOT_WIDTH-2:0] rd_ptr;

  sched_pkg::slot_t mem [sched_pkg::SLOT_COUNT];

  assign ready = (count != sched_pkg::SLOT_COUNT);
  assign valid = (count != 0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together keep the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst) push |-> ready
  ) else $error("slot_fifo push while full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst) pop |-> valid
  ) else $error("slot_fifo pop while empty");

endmodule

//--- rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [sched_pkg::PORT_COUNT-1:0]    req,
  output logic [sched_pkg::PORT_COUNT-1:0]    grant,
  output logic                                grant_valid,
  output logic [sched_pkg::PORT_ID_WIDTH-1:0] grant_index
);

  // Port with the highest priority this cycle
  logic [sched_pkg::PORT_ID_WIDTH-1:0] ptr;

  // Search starts at the pointer and wraps around the ports
  always_comb begin : pick
    int idx;
    grant       = '0;
    grant_valid = 1'b0;
    grant_index = '0;
    for (int i = 0; i < sched_pkg::PORT_COUNT; i++) begin
      idx = (int'(ptr) + i) % sched_pkg::PORT_COUNT;
      if (req[idx] && !grant_valid) begin
        grant[idx]  = 1'b1;
        grant_valid = 1'b1;
        grant_index = idx[sched_pkg::PORT_ID_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (grant_valid) begin
      if (grant_index == (sched_pkg::PORT_COUNT - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= grant_index + 1'b1;
      end
    end
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(grant)
  ) else $error("rr_arbiter grant is not one-hot");

endmodule

//--- sched_pkg.sv
package sched_pkg;

  // Sizes of the scheduler
  localparam int PORT_COUNT = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;

  localparam int DATA_WIDTH = 32;
  localparam int KEEP_WIDTH = 4;

  // Slot field of a descriptor word starts at this bit
  localparam int LEN_WIDTH = 16;

  // One extra bit so a count can hold SLOT_COUNT itself
  localparam int SLOT_WIDTH    = 3;
  localparam int CORE_ID_WIDTH = 2;
  localparam int PORT_ID_WIDTH = 1;
  localparam int TAG_WIDTH     = CORE_ID_WIDTH + SLOT_WIDTH;

  typedef logic [SLOT_WIDTH-1:0]    slot_t;
  typedef logic [SLOT_WIDTH-1:0]    count_t;
  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;

  // Core id in the upper bits, slot number below
  typedef logic [TAG_WIDTH-1:0]     tag_t;

endpackage
